/* aes_encrypt.f */
+incdir+test
hdl/aes_defs_pkg.sv
hdl/aes_tables_pkg.sv
hdl/aes_round_if.sv
hdl/aes_round.sv
hdl/aes_key_sched.sv
hdl/aes_sequencer.sv
hdl/aes_encrypt.sv
test/aes_clock_gen.sv
test/tb_aes_encrypt.sv

/* hdl/aes_defs_pkg.sv */
package aes_defs_pkg;

  // AES state, column-major with byte 0 in the top bits as in FIPS-197
  typedef logic [127:0] block_t;

  // Cipher key or one expanded round key
  typedef logic [127:0] key_t;

  // One 32-bit word of the key schedule
  typedef logic [31:0] word_t;

  // Round index, 0 is the initial AddRoundKey
  typedef logic [3:0] round_t;

  // Last round index for AES-128
  localparam round_t NUM_ROUNDS = 4'd10;

endpackage

/* hdl/aes_encrypt.sv */
`timescale 1ns/1ps

module aes_encrypt (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  aes_defs_pkg::block_t  plaintext,
  input  aes_defs_pkg::key_t    key,
  output aes_defs_pkg::block_t  ciphertext,
  output logic                  done,
  output logic                  busy
);

  logic                 load;
  logic                 advance;
  aes_defs_pkg::round_t round;

  // Operands between sequencer, key schedule and round datapath
  aes_round_if rnd_if ();

  aes_sequencer i_aes_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .plaintext  (plaintext),
    .key        (key),
    .load       (load),
    .advance    (advance),
    .round      (round),
    .rnd        (rnd_if.seq),
    .ciphertext (ciphertext),
    .done       (done),
    .busy       (busy)
  );

  // Round key is driven onto the shared interface
  aes_key_sched i_aes_key_sched (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .advance   (advance),
    .key       (key),
    .round     (round),
    .round_key (rnd_if.round_key)
  );

  aes_round i_aes_round (
    .rnd (rnd_if.dp)
  );

endmodule

/* hdl/aes_key_sched.sv */
`timescale 1ns/1ps

module aes_key_sched (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  load,
  input  logic                  advance,
  input  aes_defs_pkg::key_t    key,
  input  aes_defs_pkg::round_t  round,
  output aes_defs_pkg::key_t    round_key
);

  // Previous round key, the cipher key right after a load
  aes_defs_pkg::key_t key_q;

  aes_defs_pkg::word_t w0;
  aes_defs_pkg::word_t w1;
  aes_defs_pkg::word_t w2;
  aes_defs_pkg::word_t w3;
  aes_defs_pkg::word_t rot_word;
  aes_defs_pkg::word_t sub_word;
  aes_defs_pkg::word_t temp;
  aes_defs_pkg::word_t n0;
  aes_defs_pkg::word_t n1;
  aes_defs_pkg::word_t n2;
  aes_defs_pkg::word_t n3;

  assign w0 = key_q[127:96];
  assign w1 = key_q[95:64];
  assign w2 = key_q[63:32];
  assign w3 = key_q[31:0];

  // RotWord then SubWord on the last word
  assign rot_word = {w3[23:0], w3[31:24]};
  assign sub_word = {aes_tables_pkg::sbox(rot_word[31:24]),
                     aes_tables_pkg::sbox(rot_word[23:16]),
                     aes_tables_pkg::sbox(rot_word[15:8]),
                     aes_tables_pkg::sbox(rot_word[7:0])};
  assign temp = sub_word ^ {aes_tables_pkg::rcon(round), 24'h000000};

  // Each new word chains off the one before it
  assign n0 = w0 ^ temp;
  assign n1 = w1 ^ n0;
  assign n2 = w2 ^ n1;
  assign n3 = w3 ^ n2;

  assign round_key = {n0, n1, n2, n3};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      key_q <= '0;
    end else if (load) begin
      key_q <= key;
    end else if (advance) begin
      key_q <= round_key;
    end
  end

endmodule

/* hdl/aes_round.sv */
`timescale 1ns/1ps

module aes_round (
  aes_round_if.dp rnd
);

  logic [7:0] in_bytes [16];
  logic [7:0] shifted [16];
  aes_defs_pkg::block_t shifted_block;
  aes_defs_pkg::block_t mixed_block;

  // One MixColumns column, a0 is the top byte
  function automatic logic [31:0] mix_column(input logic [31:0] col);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    logic [7:0] d0;
    logic [7:0] d1;
    logic [7:0] d2;
    logic [7:0] d3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    d0 = aes_tables_pkg::xtime(a0);
    d1 = aes_tables_pkg::xtime(a1);
    d2 = aes_tables_pkg::xtime(a2);
    d3 = aes_tables_pkg::xtime(a3);
    // 3*a is written as 2*a ^ a
    return {d0 ^ (d1 ^ a1) ^ a2 ^ a3,
            a0 ^ d1 ^ (d2 ^ a2) ^ a3,
            a0 ^ a1 ^ d2 ^ (d3 ^ a3),
            (d0 ^ a0) ^ a1 ^ a2 ^ d3};
  endfunction

  // Split the state into bytes, byte i sits at row i%4, column i/4
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      in_bytes[i] = rnd.state_in[127 - 8*i -: 8];
    end
  end

  // SubBytes and ShiftRows together
  // Row r of column c takes the byte from column (c + r) mod 4
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted[4*c + r] = aes_tables_pkg::sbox(in_bytes[4*((c + r) % 4) + r]);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 16; i++) begin
      shifted_block[127 - 8*i -: 8] = shifted[i];
    end
  end

  always_comb begin
    for (int c = 0; c < 4; c++) begin
      mixed_block[127 - 32*c -: 32] = mix_column(shifted_block[127 - 32*c -: 32]);
    end
  end

  // AddRoundKey, last round bypasses MixColumns
  assign rnd.state_out = (rnd.final_round ? shifted_block : mixed_block) ^ rnd.round_key;

endmodule

/* hdl/aes_round_if.sv */
`timescale 1ns/1ps

interface aes_round_if;

  // State entering the round datapath
  aes_defs_pkg::block_t state_in;

  // Round key from the key schedule
  aes_defs_pkg::key_t round_key;

  // High in the last round, MixColumns is skipped
  logic final_round;

  // State after the round
  aes_defs_pkg::block_t state_out;

  modport seq (
    output state_in,
    output final_round,
    input  state_out
  );

  modport dp (
    input  state_in,
    input  round_key,
    input  final_round,
    output state_out
  );

endinterface

/* hdl/aes_sequencer.sv */
`timescale 1ns/1ps

module aes_sequencer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  aes_defs_pkg::block_t  plaintext,
  input  aes_defs_pkg::key_t    key,
  output logic                  load,
  output logic                  advance,
  output aes_defs_pkg::round_t  round,
  aes_round_if.seq              rnd,
  output aes_defs_pkg::block_t  ciphertext,
  output logic                  done,
  output logic                  busy
);

  aes_defs_pkg::block_t state_q;
  aes_defs_pkg::round_t round_q;
  logic                 accept;
  logic                 last_round;

  // Starts are dropped while a block is in flight
  assign accept     = start && !busy;
  assign last_round = (round_q == aes_defs_pkg::NUM_ROUNDS);

  // Key schedule controls
  assign load    = accept;
  assign advance = busy;
  assign round   = round_q;

  // Round datapath operands
  assign rnd.state_in    = state_q;
  assign rnd.final_round = last_round;

  // State register, initial AddRoundKey on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      state_q <= plaintext ^ key;
    end else if (busy) begin
      state_q <= rnd.state_out;
    end
  end

  // Round counter and handshake flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      done       <= 1'b0;
      round_q    <= '0;
      ciphertext <= '0;
    end else begin
      done <= 1'b0;
      if (accept) begin
        busy    <= 1'b1;
        round_q <= 4'd1;
      end else if (busy) begin
        if (last_round) begin
          // Final round result goes straight to the output
          busy       <= 1'b0;
          done       <= 1'b1;
          round_q    <= '0;
          ciphertext <= rnd.state_out;
        end else begin
          round_q <= round_q + 4'd1;
        end
      end
    end
  end

endmodule

/* hdl/aes_tables_pkg.sv */
package aes_tables_pkg;

  // Forward S-box, entry 0x00 in the top byte, one table row per line
  localparam logic [2047:0] SBOX_TABLE = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  // SubBytes on a single byte
  function automatic logic [7:0] sbox(input logic [7:0] b);
    int unsigned idx;
    idx = (255 - int'(b)) * 8;
    return SBOX_TABLE[idx +: 8];
  endfunction

  // Round constant for key expansion, rounds 1 to 10
  function automatic logic [7:0] rcon(input aes_defs_pkg::round_t r);
    logic [7:0] c;
    case (r)
      4'd1:    c = 8'h01;
      4'd2:    c = 8'h02;
      4'd3:    c = 8'h04;
      4'd4:    c = 8'h08;
      4'd5:    c = 8'h10;
      4'd6:    c = 8'h20;
      4'd7:    c = 8'h40;
      4'd8:    c = 8'h80;
      4'd9:    c = 8'h1b;
      4'd10:   c = 8'h36;
      default: c = 8'h00;
    endcase
    return c;
  endfunction

  // Multiply by x in GF(2^8), reduced by x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] xtime(input logic [7:0] b);
    logic [7:0] shifted;
    shifted = {b[6:0], 1'b0};
    return b[7] ? (shifted ^ 8'h1b) : shifted;
  endfunction

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the AES-128 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f aes_encrypt.f --top-module tb_aes_encrypt -o sim_aes
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_aes
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0

/* test/aes_clock_gen.sv */
`timescale 1ns/1ps

module aes_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 50;

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD) clk = ~clk;
    end
  end

  // Reset held low over the first two rising edges
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #10;
    rst_n = 1'b1;
  end

endmodule

/* test/aes_ref_model.svh */
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

  localparam int MODEL_ROUNDS = 10;

  // Carry-less multiply in GF(2^8), reduced by 0x11b
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] x;
    acc = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ x;
      end
      x = x[7] ? ({x[6:0], 1'b0} ^ 8'h1b) : {x[6:0], 1'b0};
    end
    return acc;
  endfunction

  function automatic logic [7:0] rotl8(input logic [7:0] x, input int n);
    return (x << n) | (x >> (8 - n));
  endfunction

  // S-box from its definition, inverse then affine map
  function automatic logic [7:0] sub_byte(input logic [7:0] b);
    logic [7:0] inv;
    // b^254 by square and multiply, zero maps to zero
    inv = 8'h01;
    for (int i = 7; i >= 0; i--) begin
      inv = gf_mul(inv, inv);
      if (i != 0) begin
        inv = gf_mul(inv, b);
      end
    end
    return inv ^ rotl8(inv, 1) ^ rotl8(inv, 2) ^ rotl8(inv, 3) ^ rotl8(inv, 4) ^ 8'h63;
  endfunction

  function automatic logic [31:0] sub_word(input logic [31:0] w);
    return {sub_byte(w[31:24]), sub_byte(w[23:16]), sub_byte(w[15:8]), sub_byte(w[7:0])};
  endfunction

  function automatic logic [127:0] model_encrypt(input logic [127:0] pt, input logic [127:0] k);
    logic [31:0] w [44];
    logic [7:0] st [4][4];
    logic [7:0] tmp [4][4];
    logic [31:0] t;
    logic [7:0] rc;
    logic [127:0] result;
    // Full key expansion up front
    for (int i = 0; i < 4; i++) begin
      w[i] = k[127 - 32*i -: 32];
    end
    rc = 8'h01;
    for (int i = 4; i < 44; i++) begin
      t = w[i-1];
      if (i % 4 == 0) begin
        t = sub_word({t[23:0], t[31:24]}) ^ {rc, 24'h000000};
        rc = gf_mul(rc, 8'h02);
      end
      w[i] = w[i-4] ^ t;
    end
    // st[row][col], input byte 4*col+row
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        st[r][c] = pt[127 - 8*(4*c + r) -: 8] ^ w[c][31 - 8*r -: 8];
      end
    end
    for (int rd = 1; rd <= MODEL_ROUNDS; rd++) begin
      for (int r = 0; r < 4; r++) begin
        for (int c = 0; c < 4; c++) begin
          tmp[r][c] = sub_byte(st[r][(c + r) % 4]);
        end
      end
      for (int c = 0; c < 4; c++) begin
        if (rd != MODEL_ROUNDS) begin
          st[0][c] = gf_mul(8'h02, tmp[0][c]) ^ gf_mul(8'h03, tmp[1][c]) ^ tmp[2][c] ^ tmp[3][c];
          st[1][c] = tmp[0][c] ^ gf_mul(8'h02, tmp[1][c]) ^ gf_mul(8'h03, tmp[2][c]) ^ tmp[3][c];
          st[2][c] = tmp[0][c] ^ tmp[1][c] ^ gf_mul(8'h02, tmp[2][c]) ^ gf_mul(8'h03, tmp[3][c]);
          st[3][c] = gf_mul(8'h03, tmp[0][c]) ^ tmp[1][c] ^ tmp[2][c] ^ gf_mul(8'h02, tmp[3][c]);
        end else begin
          for (int r = 0; r < 4; r++) begin
            st[r][c] = tmp[r][c];
          end
        end
        for (int r = 0; r < 4; r++) begin
          st[r][c] = st[r][c] ^ w[4*rd + c][31 - 8*r -: 8];
        end
      end
    end
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        result[127 - 8*(4*c + r) -: 8] = st[r][c];
      end
    end
    return result;
  endfunction

`endif

/* test/tb_aes_encrypt.sv */
`timescale 1ns/1ps

module tb_aes_encrypt;

  localparam int SEED = 32'h2f4e;
  localparam int LATENCY = 10;
  localparam int DRIVE_DELAY = 10;
  localparam int NUM_RANDOM = 200;
  localparam int NUM_IGNORED = 20;
  localparam int NUM_B2B = 20;
  localparam int NUM_RESET = 5;
  localparam int MAX_GAP = 8;
  // 12 cycles per encryption plus idle gaps and reset cycles
  localparam int NUM_BLOCKS = 1 + NUM_RANDOM + NUM_IGNORED + 2 * NUM_B2B + 2 * NUM_RESET;
  localparam int TIMEOUT_CYCLES = 12 * NUM_BLOCKS + (MAX_GAP + 2) * (NUM_B2B + NUM_RESET) + 100;

  // FIPS-197 Appendix C.1
  localparam logic [127:0] KAT_KEY = 128'h000102030405060708090a0b0c0d0e0f;
  localparam logic [127:0] KAT_PT  = 128'h00112233445566778899aabbccddeeff;
  localparam logic [127:0] KAT_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

  logic         clk;
  logic         por_n;
  logic         test_rst_n;
  logic         rst_n;
  logic         start;
  logic [127:0] plaintext;
  logic [127:0] key;
  logic [127:0] ciphertext;
  logic         done;
  logic         busy;

  `include "aes_ref_model.svh"

  aes_clock_gen i_aes_clock_gen (
    .clk   (clk),
    .rst_n (por_n)
  );

  // Power-on reset combined with the mid-run reset
  assign rst_n = por_n & test_rst_n;

  aes_encrypt i_aes_encrypt (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .plaintext  (plaintext),
    .key        (key),
    .ciphertext (ciphertext),
    .done       (done),
    .busy       (busy)
  );

  task automatic wait_cycle;
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  task automatic check(input string name, input logic [127:0] expected,
                       input logic [127:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  function automatic logic [127:0] random_block();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // Starts one block and returns on the cycle where done is high
  // Noisy mode raises new starts with other inputs while busy
  task automatic run_block(input string name, input logic [127:0] pt,
                           input logic [127:0] k, input bit noisy);
    logic [127:0] expected;
    int cycles;
    expected = model_encrypt(pt, k);
    plaintext = pt;
    key = k;
    start = 1'b1;
    wait_cycle();
    start = 1'b0;
    check({name, " accepted"}, 128'd1, 128'(busy));
    cycles = 0;
    while (!done) begin
      if (noisy) begin
        plaintext = random_block();
        key = random_block();
        start = 1'b1;
      end
      wait_cycle();
      cycles++;
      if (cycles > 2 * LATENCY) begin
        $display("Block %s never raised done", name);
        $display("CHECKS FAILED");
        $fatal(1, "No done for %s", name);
      end
    end
    start = 1'b0;
    check({name, " latency"}, 128'(LATENCY), 128'(cycles));
    check({name, " busy at done"}, 128'd0, 128'(busy));
    check({name, " ciphertext"}, expected, ciphertext);
  endtask

  // Idle cycles where done stays low and the result holds
  task automatic check_idle(input string name, input int num_cycles);
    logic [127:0] held;
    held = ciphertext;
    repeat (num_cycles) begin
      wait_cycle();
      check({name, " done low"}, 128'd0, 128'(done));
      check({name, " busy low"}, 128'd0, 128'(busy));
      check({name, " hold"}, held, ciphertext);
    end
  endtask

  initial begin
    logic [127:0] pt;
    logic [127:0] k;
    int gap;
    start = 1'b0;
    plaintext = '0;
    key = '0;
    test_rst_n = 1'b1;
    void'($urandom(SEED));
    wait (por_n);
    wait_cycle();
    check("reset busy", 128'd0, 128'(busy));
    check("reset done", 128'd0, 128'(done));
    check("reset ciphertext", 128'd0, ciphertext);

    check("kat model", KAT_CT, model_encrypt(KAT_PT, KAT_KEY));
    run_block("kat", KAT_PT, KAT_KEY, 1'b0);
    check("kat constant", KAT_CT, ciphertext);
    check_idle("kat", 1);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      pt = random_block();
      k = random_block();
      run_block("random", pt, k, 1'b0);
      check_idle("random", 1);
    end

    for (int i = 0; i < NUM_IGNORED; i++) begin
      pt = random_block();
      k = random_block();
      run_block("ignored start", pt, k, 1'b1);
      check_idle("ignored start", 2);
    end

    // Second start lands on the done cycle of the first
    for (int i = 0; i < NUM_B2B; i++) begin
      pt = random_block();
      k = random_block();
      run_block("b2b first", pt, k, 1'b0);
      pt = random_block();
      k = random_block();
      run_block("b2b second", pt, k, 1'b0);
      gap = int'($urandom_range(MAX_GAP, 1));
      check_idle("idle gap", gap);
    end

    // Last pass resets on the done cycle so that done is high going in
    for (int i = 0; i < NUM_RESET; i++) begin
      plaintext = random_block();
      key = random_block();
      start = 1'b1;
      wait_cycle();
      start = 1'b0;
      if (i == NUM_RESET - 1) begin
        gap = LATENCY;
      end else begin
        gap = int'($urandom_range(LATENCY - 1, 1));
      end
      repeat (gap) wait_cycle();
      check("busy before reset", 128'(gap < LATENCY), 128'(busy));
      check("done before reset", 128'(gap == LATENCY), 128'(done));
      test_rst_n = 1'b0;
      wait_cycle();
      check("mid-run reset busy", 128'd0, 128'(busy));
      check("mid-run reset done", 128'd0, 128'(done));
      check("mid-run reset ciphertext", 128'd0, ciphertext);
      wait_cycle();
      test_rst_n = 1'b1;
      pt = random_block();
      k = random_block();
      run_block("after reset", pt, k, 1'b0);
      check_idle("after reset", 1);
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("CHECKS FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule
